// File: design/redmule_cfg_pkg.sv
// Control-side definitions for the matrix-multiply accelerator
// Register map, field positions and memory address width

package redmule_cfg_pkg;

  // Memory word address and register offset widths
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned CFG_ADDR_W = 8;
  localparam int unsigned CFG_DATA_W = 32;

  // Operand base address registers
  localparam logic [CFG_ADDR_W-1:0] REG_X_ADDR = 8'h00;
  localparam logic [CFG_ADDR_W-1:0] REG_W_ADDR = 8'h04;
  localparam logic [CFG_ADDR_W-1:0] REG_Y_ADDR = 8'h08;
  localparam logic [CFG_ADDR_W-1:0] REG_Z_ADDR = 8'h0C;

  // Matrix sizes, each field holds size minus one
  localparam logic [CFG_ADDR_W-1:0] REG_SIZES = 8'h10;
  localparam int unsigned SIZE_M_LSB = 0;
  localparam int unsigned SIZE_N_LSB = 8;
  localparam int unsigned SIZE_K_LSB = 16;
  localparam int unsigned SIZE_W     = 2;

  // Bit 0 reports a running job
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS = 8'h14;
  localparam int unsigned STATUS_BUSY_BIT = 0;

  // Any write here launches a job
  localparam logic [CFG_ADDR_W-1:0] REG_TRIGGER = 8'h54;

  typedef logic [ADDR_W-1:0] addr_t;

endpackage : redmule_cfg_pkg

// File: design/redmule_data_pkg.sv
// Datapath definitions for the matrix-multiply accelerator
// Element and accumulator types, index type and array size

package redmule_data_pkg;

  // Maximum value of M, N and K
  localparam int unsigned DIM = 4;

  localparam int unsigned ELEM_W = 16;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned IDX_W  = $clog2(DIM);

  // One element per memory word
  localparam int unsigned MEM_W = 32;

  // Operand element from X or W
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Accumulator, also the Y and Z element; wraps on overflow
  typedef logic signed [ACC_W-1:0] acc_t;

  // Row or column index inside the array
  typedef logic [IDX_W-1:0] idx_t;

endpackage : redmule_data_pkg

// File: design/redmule_job_if.sv
// Job description passed from the register block to the scheduler
// Settings stay stable from start until done

interface redmule_job_if
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
();

  // One-cycle launch and completion pulses
  logic  start;
  logic  done;

  // Operand base addresses
  addr_t x_addr;
  addr_t w_addr;
  addr_t y_addr;
  addr_t z_addr;

  // Last index along each dimension
  idx_t  m_last;
  idx_t  n_last;
  idx_t  k_last;

  modport regfile (
    output start, x_addr, w_addr, y_addr, z_addr, m_last, n_last, k_last,
    input  done
  );

  modport scheduler (
    input  start, x_addr, w_addr, y_addr, z_addr, m_last, n_last, k_last,
    output done
  );

endinterface : redmule_job_if

// File: design/redmule_regfile.sv
// Peripheral register block for the accelerator
// Holds job settings, launches jobs and reports busy and end of job

module redmule_regfile
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
  output logic [CFG_DATA_W-1:0] cfg_rdata_o,
  output logic                  busy_o,
  output logic                  evt_o,
  redmule_job_if.regfile        job
);

  addr_t x_addr_q, w_addr_q, y_addr_q, z_addr_q;
  idx_t  m_last_q, n_last_q, k_last_q;
  logic  busy_q;
  logic  start_q;
  logic  wr_en, rd_en;
  logic  [CFG_DATA_W-1:0] rd_word;

  assign wr_en = cfg_req_i && cfg_we_i;
  assign rd_en = cfg_req_i && !cfg_we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      x_addr_q <= '0;
      w_addr_q <= '0;
      y_addr_q <= '0;
      z_addr_q <= '0;
      m_last_q <= '0;
      n_last_q <= '0;
      k_last_q <= '0;
      busy_q   <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      // Settings are frozen while a job runs
      if (wr_en && !busy_q) begin
        case (cfg_addr_i)
          REG_X_ADDR: x_addr_q <= cfg_wdata_i[ADDR_W-1:0];
          REG_W_ADDR: w_addr_q <= cfg_wdata_i[ADDR_W-1:0];
          REG_Y_ADDR: y_addr_q <= cfg_wdata_i[ADDR_W-1:0];
          REG_Z_ADDR: z_addr_q <= cfg_wdata_i[ADDR_W-1:0];
          REG_SIZES: begin
            m_last_q <= idx_t'(cfg_wdata_i[SIZE_M_LSB +: SIZE_W]);
            n_last_q <= idx_t'(cfg_wdata_i[SIZE_N_LSB +: SIZE_W]);
            k_last_q <= idx_t'(cfg_wdata_i[SIZE_K_LSB +: SIZE_W]);
          end
          REG_TRIGGER: begin
            start_q <= 1'b1;
            busy_q  <= 1'b1;
          end
          default: ;
        endcase
      end else if (job.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    rd_word = '0;
    case (cfg_addr_i)
      REG_X_ADDR: rd_word[ADDR_W-1:0] = x_addr_q;
      REG_W_ADDR: rd_word[ADDR_W-1:0] = w_addr_q;
      REG_Y_ADDR: rd_word[ADDR_W-1:0] = y_addr_q;
      REG_Z_ADDR: rd_word[ADDR_W-1:0] = z_addr_q;
      REG_SIZES: begin
        rd_word[SIZE_M_LSB +: SIZE_W] = m_last_q;
        rd_word[SIZE_N_LSB +: SIZE_W] = n_last_q;
        rd_word[SIZE_K_LSB +: SIZE_W] = k_last_q;
      end
      REG_STATUS: rd_word[STATUS_BUSY_BIT] = busy_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      cfg_rdata_o <= rd_word;
    end
  end

  assign job.start  = start_q;
  assign job.x_addr = x_addr_q;
  assign job.w_addr = w_addr_q;
  assign job.y_addr = y_addr_q;
  assign job.z_addr = z_addr_q;
  assign job.m_last = m_last_q;
  assign job.n_last = n_last_q;
  assign job.k_last = k_last_q;

  assign busy_o = busy_q;
  // End-of-job event coincides with the last Z write
  assign evt_o  = job.done;

  // A job is only launched from idle
  a_start_from_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job.start |-> !$past(busy_q));

  // The scheduler finishes only a job that was launched
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job.done |-> busy_q);

endmodule : redmule_regfile

// File: design/redmule_scheduler.sv
// Job sequencer for the accelerator
// Streams W, then per row Y and X from memory, drains the MAC pipe
// and writes the Z row back

module redmule_scheduler
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  redmule_job_if.scheduler job,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output addr_t            mem_addr_o,
  output logic [MEM_W-1:0] mem_wdata_o,
  input  logic [MEM_W-1:0] mem_rdata_i,
  output logic             w_we_o,
  output idx_t             w_row_o,
  output idx_t             w_col_o,
  output logic             y_we_o,
  output idx_t             col_o,
  output logic             mac_valid_o,
  output idx_t             mac_row_o,
  input  acc_t             z_data_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_W,
    ST_LOAD_Y,
    ST_STREAM_X,
    ST_DRAIN,
    ST_STORE_Z
  } state_e;

  // Kind of read whose data returns next cycle
  typedef enum logic [1:0] {
    KIND_NONE,
    KIND_W,
    KIND_Y,
    KIND_X
  } kind_e;

  state_e     state_q;
  kind_e      rd_kind_q;
  idx_t       row_q;
  idx_t       inner_q;
  idx_t       col_q;
  logic       drain_q;
  idx_t       rd_row_q, rd_col_q;
  logic [2:0] n_len, k_len;
  addr_t      w_off, mk_off, x_off;

  assign n_len = {1'b0, job.n_last} + 3'd1;
  assign k_len = {1'b0, job.k_last} + 3'd1;

  // Row-major offsets; mk_off serves both Y and Z
  assign w_off  = addr_t'(inner_q) * addr_t'(k_len) + addr_t'(col_q);
  assign mk_off = addr_t'(row_q) * addr_t'(k_len) + addr_t'(col_q);
  assign x_off  = addr_t'(row_q) * addr_t'(n_len) + addr_t'(inner_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      rd_kind_q <= KIND_NONE;
      row_q     <= '0;
      inner_q   <= '0;
      col_q     <= '0;
      drain_q   <= 1'b0;
    end else begin
      rd_kind_q <= KIND_NONE;
      case (state_q)
        ST_IDLE: begin
          if (job.start) begin
            state_q <= ST_LOAD_W;
            row_q   <= '0;
            inner_q <= '0;
            col_q   <= '0;
          end
        end
        ST_LOAD_W: begin
          rd_kind_q <= KIND_W;
          if (col_q == job.k_last) begin
            col_q <= '0;
            if (inner_q == job.n_last) begin
              inner_q <= '0;
              state_q <= ST_LOAD_Y;
            end else begin
              inner_q <= inner_q + 1'b1;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        ST_LOAD_Y: begin
          rd_kind_q <= KIND_Y;
          if (col_q == job.k_last) begin
            col_q   <= '0;
            state_q <= ST_STREAM_X;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        ST_STREAM_X: begin
          rd_kind_q <= KIND_X;
          if (inner_q == job.n_last) begin
            inner_q <= '0;
            drain_q <= 1'b0;
            state_q <= ST_DRAIN;
          end else begin
            inner_q <= inner_q + 1'b1;
          end
        end
        // Two cycles for the last product to reach its accumulator
        ST_DRAIN: begin
          drain_q <= 1'b1;
          if (drain_q) begin
            state_q <= ST_STORE_Z;
          end
        end
        ST_STORE_Z: begin
          if (col_q == job.k_last) begin
            col_q <= '0;
            if (row_q == job.m_last) begin
              state_q <= ST_IDLE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= ST_LOAD_Y;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Indices of the outstanding read, steered with its data
  always_ff @(posedge clk_i) begin
    rd_row_q <= inner_q;
    rd_col_q <= col_q;
  end

  always_comb begin
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    mem_addr_o = '0;
    case (state_q)
      ST_LOAD_W: begin
        mem_req_o  = 1'b1;
        mem_addr_o = job.w_addr + w_off;
      end
      ST_LOAD_Y: begin
        mem_req_o  = 1'b1;
        mem_addr_o = job.y_addr + mk_off;
      end
      ST_STREAM_X: begin
        mem_req_o  = 1'b1;
        mem_addr_o = job.x_addr + x_off;
      end
      ST_STORE_Z: begin
        mem_req_o  = 1'b1;
        mem_we_o   = 1'b1;
        mem_addr_o = job.z_addr + mk_off;
      end
      default: ;
    endcase
  end

  assign mem_wdata_o = z_data_i;

  assign w_we_o      = (rd_kind_q == KIND_W);
  assign w_row_o     = rd_row_q;
  assign w_col_o     = rd_col_q;
  assign y_we_o      = (rd_kind_q == KIND_Y);
  assign mac_valid_o = (rd_kind_q == KIND_X);
  assign mac_row_o   = rd_row_q;
  // Store phase selects the Z column, otherwise the returning Y column
  assign col_o       = (state_q == ST_STORE_Z) ? col_q : rd_col_q;

  assign job.done = (state_q == ST_STORE_Z) && (col_q == job.k_last) &&
                    (row_q == job.m_last);

  a_no_req_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == ST_IDLE && !job.start) |=> !mem_req_o);

  a_w_y_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(w_we_o && y_we_o));

  // Memory answers every read one cycle later
  a_rdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rd_kind_q != KIND_NONE) |-> !$isunknown(mem_rdata_i));

endmodule : redmule_scheduler

// File: design/redmule_engine.sv
// Multiply-accumulate engine for the accelerator
// W buffer and one two-stage MAC lane per output column

module redmule_engine
  import redmule_data_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  w_we_i,
  input  idx_t  w_row_i,
  input  idx_t  w_col_i,
  input  elem_t w_data_i,
  input  logic  y_we_i,
  input  idx_t  col_i,
  input  acc_t  y_data_i,
  input  logic  mac_valid_i,
  input  idx_t  mac_row_i,
  input  elem_t x_data_i,
  output acc_t  z_data_o
);

  elem_t w_buf_q [DIM][DIM];
  acc_t  prod_q  [DIM];
  acc_t  acc_q   [DIM];
  logic  prod_vld_q;

  always_ff @(posedge clk_i) begin
    if (w_we_i) begin
      w_buf_q[w_row_i][w_col_i] <= w_data_i;
    end
  end

  // Stage 1, x broadcast against one W row
  always_ff @(posedge clk_i) begin
    if (mac_valid_i) begin
      for (int k = 0; k < DIM; k++) begin
        prod_q[k] <= acc_t'(x_data_i) * acc_t'(w_buf_q[mac_row_i][k]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prod_vld_q <= 1'b0;
    end else begin
      prod_vld_q <= mac_valid_i;
    end
  end

  // Stage 2, Y bias load or accumulate
  always_ff @(posedge clk_i) begin
    if (y_we_i) begin
      acc_q[col_i] <= y_data_i;
    end else if (prod_vld_q) begin
      for (int k = 0; k < DIM; k++) begin
        acc_q[k] <= acc_q[k] + prod_q[k];
      end
    end
  end

  assign z_data_o = acc_q[col_i];

  // Bias loads never overlap a product still in flight
  a_y_vs_acc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(mac_valid_i) |-> !y_we_i);

endmodule : redmule_engine

// File: design/redmule_top.sv
// Matrix-multiply accelerator top level, Z = Y + X*W
// Connects the register block, scheduler and engine to plain ports

module redmule_top
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
  output logic [CFG_DATA_W-1:0] cfg_rdata_o,
  output logic                  busy_o,
  output logic                  evt_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output addr_t                 mem_addr_o,
  output logic [MEM_W-1:0]      mem_wdata_o,
  input  logic [MEM_W-1:0]      mem_rdata_i
);

  logic  w_we, y_we, mac_valid;
  idx_t  w_row, w_col, col, mac_row;
  acc_t  z_data;
  elem_t rd_elem;
  acc_t  rd_acc;

  // X and W sit in the low half of the word, Y uses the whole word
  assign rd_elem = elem_t'(mem_rdata_i[ELEM_W-1:0]);
  assign rd_acc  = acc_t'(mem_rdata_i);

  redmule_job_if job ();

  redmule_regfile i_regfile (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .busy_o      ( busy_o      ),
    .evt_o       ( evt_o       ),
    .job         ( job         )
  );

  redmule_scheduler i_scheduler (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .job         ( job         ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_rdata_i ( mem_rdata_i ),
    .w_we_o      ( w_we        ),
    .w_row_o     ( w_row       ),
    .w_col_o     ( w_col       ),
    .y_we_o      ( y_we        ),
    .col_o       ( col         ),
    .mac_valid_o ( mac_valid   ),
    .mac_row_o   ( mac_row     ),
    .z_data_i    ( z_data      )
  );

  redmule_engine i_engine (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .w_we_i      ( w_we        ),
    .w_row_i     ( w_row       ),
    .w_col_i     ( w_col       ),
    .w_data_i    ( rd_elem     ),
    .y_we_i      ( y_we        ),
    .col_i       ( col         ),
    .y_data_i    ( rd_acc      ),
    .mac_valid_i ( mac_valid   ),
    .mac_row_i   ( mac_row     ),
    .x_data_i    ( rd_elem     ),
    .z_data_o    ( z_data      )
  );

endmodule : redmule_top

// File: tb/redmule_checker.sv
// Scoreboard for the accelerator testbench
// Checks Z writes, register reads, busy and the end-of-job event

module redmule_checker
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          mem_req_i,
  input  logic                          mem_we_i,
  input  addr_t                         mem_addr_i,
  input  logic [MEM_W-1:0]              mem_wdata_i,
  input  logic                          busy_i,
  input  logic                          evt_i,
  input  logic [CFG_ADDR_W-1:0]         cfg_addr_i,
  input  logic [CFG_DATA_W-1:0]         cfg_rdata_i,
  input  logic                          rd_chk_i,
  input  logic [CFG_DATA_W-1:0]         rd_exp_i,
  input  logic                          job_active_i,
  input  logic                          test_start_i,
  input  logic                          test_done_i,
  input  int                            test_id_i,
  input  addr_t                         z_base_i,
  input  int                            z_len_i,
  input  logic [DIM*DIM-1:0][ACC_W-1:0] z_exp_i,
  output int                            err_count_o,
  output int                            check_count_o
);

  int   hits [DIM*DIM];
  int   errs = 0;
  int   checks = 0;
  int   test_errs = 0;
  int   evt_count = 0;
  logic evt_prev = 1'b0;

  assign err_count_o   = errs;
  assign check_count_o = checks;

  task automatic count_error();
    test_errs++;
    errs++;
  endtask

  // Sampled mid-cycle, where DUT outputs and testbench drives are settled
  always @(negedge clk_i) begin
    addr_t off;
    if (!rst_n_i) begin
      evt_prev = 1'b0;
    end else begin
      if (test_start_i) begin
        foreach (hits[i]) begin
          hits[i] = 0;
        end
        test_errs = 0;
        evt_count = 0;
      end

      // Busy and event only after a trigger
      if (!job_active_i && (busy_i || evt_i)) begin
        $display("Test %0d: busy_o or evt_o is high with no job running", test_id_i);
        count_error();
      end
      if (evt_prev && busy_i) begin
        $display("Test %0d: busy_o is still high in the cycle after evt_o", test_id_i);
        count_error();
      end
      // Memory traffic belongs to a running job
      if (mem_req_i && !busy_i) begin
        $display("Test %0d: memory request while busy_o is low", test_id_i);
        count_error();
      end
      if (evt_i) begin
        evt_count++;
      end
      evt_prev = evt_i;

      if (mem_req_i && mem_we_i) begin
        checks++;
        off = mem_addr_i - z_base_i;
        if (int'(off) >= z_len_i) begin
          $display("Test %0d: memory write at address %h lies outside the Z region",
                   test_id_i, mem_addr_i);
          count_error();
        end else begin
          hits[off]++;
          if (hits[off] > 1) begin
            $display("Test %0d: Z word %0d was written more than once", test_id_i, off);
            count_error();
          end
          if (mem_wdata_i !== z_exp_i[off]) begin
            $display("[ERROR] t=%0t test %0d Z word %0d expected %h got %h",
                     $time, test_id_i, off, z_exp_i[off], mem_wdata_i);
            count_error();
          end
        end
      end

      if (rd_chk_i) begin
        checks++;
        if (cfg_rdata_i !== rd_exp_i) begin
          $display("[ERROR] t=%0t test %0d register %h expected %h got %h",
                   $time, test_id_i, cfg_addr_i, rd_exp_i, cfg_rdata_i);
          count_error();
        end
      end

      if (test_done_i) begin
        for (int i = 0; i < z_len_i; i++) begin
          checks++;
          if (hits[i] == 0) begin
            $display("Test %0d: Z word %0d was never written", test_id_i, i);
            count_error();
          end
        end
        if (z_len_i > 0 && evt_count != 1) begin
          $display("Test %0d: saw %0d end-of-job events instead of one", test_id_i, evt_count);
          count_error();
        end
        $display("Test %0d finished: %s, %0d errors", test_id_i,
                 (test_errs == 0) ? "pass" : "FAIL", test_errs);
      end
    end
  end

endmodule : redmule_checker

// File: tb/tb_redmule.sv
// Testbench for the matrix-multiply accelerator
// Models the memory, programs the registers and runs a table of jobs

module tb_redmule
  import redmule_cfg_pkg::*;
  import redmule_data_pkg::*;
();

  localparam int NUM_JOBS    = 6;
  localparam int EVT_TIMEOUT = 500;

  // Traffic adds setting writes and a second trigger while busy
  typedef struct packed {
    logic [2:0] m;
    logic [2:0] n;
    logic [2:0] k;
    addr_t      x_base;
    addr_t      w_base;
    addr_t      y_base;
    addr_t      z_base;
    logic       traffic;
  } job_row_t;

  job_row_t jobs [NUM_JOBS] = '{
    '{3'd4, 3'd4, 3'd4, 16'h0100, 16'h0200, 16'h0300, 16'h0400, 1'b0},
    '{3'd1, 3'd3, 3'd2, 16'h1000, 16'h1010, 16'h1020, 16'h1030, 1'b0},
    '{3'd4, 3'd1, 3'd4, 16'h2000, 16'h2100, 16'h2200, 16'h2300, 1'b1},
    '{3'd2, 3'd4, 3'd1, 16'h3000, 16'h3008, 16'h3010, 16'h3018, 1'b0},
    '{3'd4, 3'd4, 3'd4, 16'h4000, 16'h4040, 16'h4080, 16'h40c0, 1'b1},
    '{3'd3, 3'd2, 3'd3, 16'h0500, 16'h0510, 16'h0520, 16'h0530, 1'b0}
  };

  logic                          clk;
  logic                          rst_n;
  logic                          cfg_req;
  logic                          cfg_we;
  logic [CFG_ADDR_W-1:0]         cfg_addr;
  logic [CFG_DATA_W-1:0]         cfg_wdata;
  logic [CFG_DATA_W-1:0]         cfg_rdata;
  logic                          busy;
  logic                          evt;
  logic                          mem_req;
  logic                          mem_we;
  addr_t                         mem_addr;
  logic [MEM_W-1:0]              mem_wdata;
  logic [MEM_W-1:0]              mem_rdata;
  logic [MEM_W-1:0]              mem [1 << ADDR_W];
  logic                          rd_chk;
  logic [CFG_DATA_W-1:0]         rd_exp;
  logic                          job_active;
  logic                          test_start;
  logic                          test_done;
  int                            test_id;
  addr_t                         z_base;
  int                            z_len;
  logic [DIM*DIM-1:0][ACC_W-1:0] z_exp;
  int                            err_count;
  int                            check_count;
  int                            tests_run;
  logic                          timed_out;

  redmule_top UUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .cfg_req_i   ( cfg_req   ),
    .cfg_we_i    ( cfg_we    ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_wdata_i ( cfg_wdata ),
    .cfg_rdata_o ( cfg_rdata ),
    .busy_o      ( busy      ),
    .evt_o       ( evt       ),
    .mem_req_o   ( mem_req   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata )
  );

  redmule_checker i_checker (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .mem_req_i     ( mem_req     ),
    .mem_we_i      ( mem_we      ),
    .mem_addr_i    ( mem_addr    ),
    .mem_wdata_i   ( mem_wdata   ),
    .busy_i        ( busy        ),
    .evt_i         ( evt         ),
    .cfg_addr_i    ( cfg_addr    ),
    .cfg_rdata_i   ( cfg_rdata   ),
    .rd_chk_i      ( rd_chk      ),
    .rd_exp_i      ( rd_exp      ),
    .job_active_i  ( job_active  ),
    .test_start_i  ( test_start  ),
    .test_done_i   ( test_done   ),
    .test_id_i     ( test_id     ),
    .z_base_i      ( z_base      ),
    .z_len_i       ( z_len       ),
    .z_exp_i       ( z_exp       ),
    .err_count_o   ( err_count   ),
    .check_count_o ( check_count )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory model, writes land at once and read data follows one cycle later
  initial begin
    logic  rd_pend;
    addr_t req_addr;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      rd_pend  = (mem_req === 1'b1) && (mem_we === 1'b0);
      req_addr = mem_addr;
      if (mem_req === 1'b1 && mem_we === 1'b1) begin
        mem[req_addr] = mem_wdata;
      end
      @(posedge clk);
      #1;
      mem_rdata = rd_pend ? mem[req_addr] : '0;
    end
  end

  // Row-major word addresses of the operands
  function automatic addr_t x_word(input job_row_t row, input int m, input int n);
    return addr_t'(row.x_base + m * row.n + n);
  endfunction

  function automatic addr_t w_word(input job_row_t row, input int n, input int k);
    return addr_t'(row.w_base + n * row.k + k);
  endfunction

  function automatic addr_t y_word(input job_row_t row, input int m, input int k);
    return addr_t'(row.y_base + m * row.k + k);
  endfunction

  function automatic logic [CFG_DATA_W-1:0] size_word(input job_row_t row);
    logic [CFG_DATA_W-1:0] w;
    w = '0;
    w[SIZE_M_LSB +: SIZE_W] = SIZE_W'(row.m - 3'd1);
    w[SIZE_N_LSB +: SIZE_W] = SIZE_W'(row.n - 3'd1);
    w[SIZE_K_LSB +: SIZE_W] = SIZE_W'(row.k - 3'd1);
    return w;
  endfunction

  // Random operands, then Z = Y + X*W with 16-bit signed elements
  task automatic load_operands(input job_row_t row);
    int acc;
    for (int m = 0; m < row.m; m++) begin
      for (int n = 0; n < row.n; n++) begin
        mem[x_word(row, m, n)] = $urandom;
      end
    end
    for (int n = 0; n < row.n; n++) begin
      for (int k = 0; k < row.k; k++) begin
        mem[w_word(row, n, k)] = $urandom;
      end
    end
    z_exp = '0;
    for (int m = 0; m < row.m; m++) begin
      for (int k = 0; k < row.k; k++) begin
        mem[y_word(row, m, k)] = $urandom;
        acc = int'(mem[y_word(row, m, k)]);
        for (int n = 0; n < row.n; n++) begin
          acc += int'(shortint'(mem[x_word(row, m, n)][15:0])) *
                 int'(shortint'(mem[w_word(row, n, k)][15:0]));
        end
        z_exp[m * row.k + k] = acc;
      end
    end
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr,
                           input logic [CFG_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cfg_req   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_req = 1'b0;
    cfg_we  = 1'b0;
  endtask

  // Read data is checked in the cycle after the request
  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr,
                          input logic [CFG_DATA_W-1:0] exp);
    @(posedge clk);
    #1;
    cfg_req  = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = addr;
    @(posedge clk);
    #1;
    cfg_req = 1'b0;
    rd_chk  = 1'b1;
    rd_exp  = exp;
    @(posedge clk);
    #1;
    rd_chk = 1'b0;
  endtask

  task automatic program_job(input addr_t x, input addr_t w, input addr_t y,
                             input addr_t z, input logic [CFG_DATA_W-1:0] sizes);
    cfg_write(REG_X_ADDR, CFG_DATA_W'(x));
    cfg_write(REG_W_ADDR, CFG_DATA_W'(w));
    cfg_write(REG_Y_ADDR, CFG_DATA_W'(y));
    cfg_write(REG_Z_ADDR, CFG_DATA_W'(z));
    cfg_write(REG_SIZES, sizes);
  endtask

  task automatic read_settings(input addr_t x, input addr_t w, input addr_t y,
                               input addr_t z, input logic [CFG_DATA_W-1:0] sizes);
    cfg_read(REG_X_ADDR, CFG_DATA_W'(x));
    cfg_read(REG_W_ADDR, CFG_DATA_W'(w));
    cfg_read(REG_Y_ADDR, CFG_DATA_W'(y));
    cfg_read(REG_Z_ADDR, CFG_DATA_W'(z));
    cfg_read(REG_SIZES, sizes);
  endtask

  task automatic begin_test(input int id, input addr_t base, input int len);
    @(posedge clk);
    #1;
    test_id    = id;
    z_base     = base;
    z_len      = len;
    test_start = 1'b1;
    @(posedge clk);
    #1;
    test_start = 1'b0;
    tests_run++;
  endtask

  task automatic end_test();
    @(posedge clk);
    #1;
    test_done = 1'b1;
    @(posedge clk);
    #1;
    test_done = 1'b0;
  endtask

  task automatic wait_for_event(input int id);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (evt !== 1'b1 && cycles < EVT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (evt !== 1'b1) begin
      $display("Timeout: test %0d saw no end-of-job event within %0d cycles", id, EVT_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_job(input int id, input job_row_t row);
    logic [CFG_DATA_W-1:0] sizes;
    sizes = size_word(row);
    load_operands(row);
    begin_test(id, row.z_base, int'(row.m) * int'(row.k));
    program_job(row.x_base, row.w_base, row.y_base, row.z_base, sizes);
    job_active = 1'b1;
    cfg_write(REG_TRIGGER, 32'h1);
    cfg_read(REG_STATUS, 32'h1);
    if (row.traffic) begin
      program_job(~row.x_base, ~row.w_base, ~row.y_base, ~row.z_base, ~sizes);
      cfg_write(REG_TRIGGER, 32'h1);
    end
    wait_for_event(id);
    if (!timed_out) begin
      repeat (2) @(posedge clk);
      #1;
      job_active = 1'b0;
      if (row.traffic) begin
        read_settings(row.x_base, row.w_base, row.y_base, row.z_base, sizes);
      end
      cfg_read(REG_STATUS, 32'h0);
      end_test();
    end
  endtask

  initial begin
    void'($urandom(32'h3d7ecb22));
    rst_n      = 1'b0;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    rd_chk     = 1'b0;
    rd_exp     = '0;
    job_active = 1'b0;
    test_start = 1'b0;
    test_done  = 1'b0;
    test_id    = 0;
    z_base     = '0;
    z_len      = 0;
    z_exp      = '0;
    tests_run  = 0;
    timed_out  = 1'b0;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = {~a[15:0], a[15:0]};
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Register access with no job
    begin_test(0, '0, 0);
    cfg_read(REG_STATUS, 32'h0);
    program_job(16'h1a2b, 16'h3c4d, 16'h5e6f, 16'h7081, 32'h0002_0103);
    read_settings(16'h1a2b, 16'h3c4d, 16'h5e6f, 16'h7081, 32'h0002_0103);
    cfg_read(REG_STATUS, 32'h0);
    end_test();

    for (int t = 0; t < NUM_JOBS && !timed_out; t++) begin
      run_job(t + 1, jobs[t]);
    end

    repeat (4) @(posedge clk);
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_redmule

// File: all.f
design/redmule_cfg_pkg.sv
design/redmule_data_pkg.sv
design/redmule_job_if.sv
design/redmule_regfile.sv
design/redmule_scheduler.sv
design/redmule_engine.sv
design/redmule_top.sv
tb/redmule_checker.sv
tb/tb_redmule.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_redmule -f all.f -o sim_redmule

./obj_dir/sim_redmule | tee sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0
